/* branch_target_buf.sv */
`timescale 1ns/100ps

module branch_target_buf
#(
   parameter int btb_p_sets = 4
)
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  fetch_types_pkg::pc_t         pc_nxt,
   input  fetch_types_pkg::btb_update_t wb,
   output fetch_types_pkg::btb_pred_t   pred
);
   import fetch_cfg_pkg::*;
   import fetch_types_pkg::*;

   localparam int n_entries = 1 << btb_p_sets;
   localparam int tag_w = pc_w - btb_p_sets;

   logic [tag_w-1:0]      tag_mem [n_entries];
   pc_t                   tgt_mem [n_entries];
   logic [n_entries-1:0]  vld;
   logic [btb_p_sets-1:0] look_idx [fetch_w];
   logic [tag_w-1:0]      look_tag [fetch_w];
   logic [btb_p_sets-1:0] wb_idx;
   logic [tag_w-1:0]      wb_tag;

   // One lookup per slot of the window at pc_nxt
   always_comb
   begin
      for (int i = 0; i < fetch_w; i++)
      begin
         look_idx[i] = btb_p_sets'({pc_nxt[pc_w-1:p_fetch_w], p_fetch_w'(i)});
         look_tag[i] = pc_nxt[pc_w-1:btb_p_sets];
      end
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < fetch_w; i++)
      begin
         if (!rst_n)
            pred.slot[i].hit <= 1'b0;
         else
            pred.slot[i].hit <= vld[look_idx[i]] && (tag_mem[look_idx[i]] == look_tag[i]);
         pred.slot[i].tgt <= tgt_mem[look_idx[i]];
      end
   end

   assign wb_idx = wb.pc[btb_p_sets-1:0];
   assign wb_tag = wb.pc[pc_w-1:btb_p_sets];

   // Taken installs the entry, not-taken drops it on a tag match
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         vld <= '0;
      else if (wb.valid)
      begin
         if (wb.taken)
            vld[wb_idx] <= 1'b1;
         else if (tag_mem[wb_idx] == wb_tag)
            vld[wb_idx] <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wb.valid && wb.taken)
      begin
         tag_mem[wb_idx] <= wb_tag;
         tgt_mem[wb_idx] <= wb.target;
      end
   end

   // Execute never reports a taken branch onto itself
   assert property (@(posedge clk) disable iff (!rst_n)
      (wb.valid && wb.taken) |-> (wb.target != wb.pc));

endmodule

/* fetch_cfg_pkg.sv */
package fetch_cfg_pkg;

   // Word-address PC, the two byte-offset bits are not carried
   localparam int pc_w = 30;

   // Instruction word
   localparam int insn_w = 32;

   // Fetch window of 2**p_fetch_w slots, aligned on its own size
   localparam int p_fetch_w = 1;
   localparam int fetch_w = 1 << p_fetch_w;

   // Slots decode may take per cycle
   localparam int issue_w = 2;

endpackage

/* fetch_frontend.sv */
`timescale 1ns/100ps

module fetch_frontend
#(
   parameter fetch_types_pkg::pc_t reset_pc = '0,
   parameter int btb_p_sets = 4,
   parameter int imem_p_words = 8,
   parameter int queue_p_depth = 3
)
(
   input  logic                                                      clk,
   input  logic                                                      rst_n,
   input  logic                                                      flush,
   input  fetch_types_pkg::pc_t                                      flush_tgt,
   input  fetch_types_pkg::btb_update_t                              btb_wb,
   input  fetch_types_pkg::imem_write_t                              imem_wr,
   input  fetch_types_pkg::slot_cnt_t                                id_pop_cnt,
   output logic [fetch_cfg_pkg::issue_w-1:0]                         id_valid,
   output fetch_types_pkg::decode_slot_t [fetch_cfg_pkg::issue_w-1:0] id_slot
);
   import fetch_cfg_pkg::*;
   import fetch_types_pkg::*;

   pc_t                 pc_nxt;
   btb_pred_t           pred;
   insn_t [fetch_w-1:0] words;
   fetch_window_t       window;
   logic                fetch_ce;

   fetch_pc_gen
      #(.reset_pc       (reset_pc))
   u_pc_gen
      (.clk             (clk),
       .rst_n           (rst_n),
       .flush           (flush),
       .fetch_ce        (fetch_ce),
       .flush_tgt       (flush_tgt),
       .pred            (pred),
       .pc_nxt          (pc_nxt),
       .window          (window));

   // Both read at pc_nxt so their data lines up with the PC register
   branch_target_buf
      #(.btb_p_sets     (btb_p_sets))
   u_btb
      (.clk             (clk),
       .rst_n           (rst_n),
       .pc_nxt          (pc_nxt),
       .wb              (btb_wb),
       .pred            (pred));

   insn_mem
      #(.imem_p_words   (imem_p_words))
   u_imem
      (.clk             (clk),
       .pc_nxt          (pc_nxt),
       .wr              (imem_wr),
       .words           (words));

   fetch_queue
      #(.queue_p_depth  (queue_p_depth))
   u_queue
      (.clk             (clk),
       .rst_n           (rst_n),
       .flush           (flush),
       .window          (window),
       .words           (words),
       .id_pop_cnt      (id_pop_cnt),
       .fq_ready        (fetch_ce),
       .id_valid        (id_valid),
       .id_slot         (id_slot));

endmodule

/* fetch_pc_gen.sv */
`timescale 1ns/100ps

module fetch_pc_gen
#(
   parameter fetch_types_pkg::pc_t reset_pc = '0
)
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           flush,
   input  logic                           fetch_ce,
   input  fetch_types_pkg::pc_t           flush_tgt,
   input  fetch_types_pkg::btb_pred_t     pred,
   output fetch_types_pkg::pc_t           pc_nxt,
   output fetch_types_pkg::fetch_window_t window
);
   import fetch_cfg_pkg::*;
   import fetch_types_pkg::*;

   pc_t                  pc;
   logic                 s1_valid;
   logic [p_fetch_w-1:0] entry_slot;
   logic [fetch_w-1:0]   aligned;
   logic [fetch_w-1:0]   valid_msk;
   slot_cnt_t            push_cnt;
   logic                 pred_taken;
   pc_t                  pred_tgt;

   // Slot of the window that the PC enters at
   assign entry_slot = pc[p_fetch_w-1:0];

   // Slots below the entry slot belong to an earlier window
   always_comb
   begin
      for (int i = 0; i < fetch_w; i++)
      begin
         aligned[i] = s1_valid && (entry_slot <= i);
      end
   end

   // Cut the window after the first predicted-taken slot
   always_comb
   begin
      logic cut;
      cut = 1'b0;
      pred_taken = 1'b0;
      pred_tgt = '0;
      for (int i = 0; i < fetch_w; i++)
      begin
         valid_msk[i] = aligned[i] && !cut;
         if (valid_msk[i] && pred.slot[i].hit)
         begin
            cut = 1'b1;
            pred_taken = 1'b1;
            pred_tgt = pred.slot[i].tgt;
         end
      end
   end

   assign push_cnt = slot_cnt_t'($countones(valid_msk));

   // Next PC: flush, stall, prediction, sequential
   always_comb
   begin
      if (flush)
         pc_nxt = flush_tgt;
      else if (!fetch_ce || !s1_valid)
         pc_nxt = pc;
      else if (pred_taken)
         pc_nxt = pred_tgt;
      else
         pc_nxt = pc + pc_t'(push_cnt);
   end

   // s1_valid stays low for one cycle so the first lookup lines up with reset_pc
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pc <= reset_pc;
         s1_valid <= 1'b0;
      end
      else
      begin
         pc <= pc_nxt;
         s1_valid <= 1'b1;
      end
   end

   always_comb
   begin
      for (int i = 0; i < fetch_w; i++)
      begin
         window.pc[i] = {pc[pc_w-1:p_fetch_w], p_fetch_w'(i)};
      end
      window.valid = valid_msk;
      window.push_off = slot_cnt_t'(entry_slot);
   end

   // A redirect lands on its target with the entry slot live
   assert property (@(posedge clk) disable iff (!rst_n)
      flush |=> (pc == $past(flush_tgt)) && window.valid[entry_slot]);

endmodule

/* fetch_queue.sv */
`timescale 1ns/100ps

module fetch_queue
#(
   parameter int queue_p_depth = 3
)
(
   input  logic                                                      clk,
   input  logic                                                      rst_n,
   input  logic                                                      flush,
   input  fetch_types_pkg::fetch_window_t                            window,
   input  fetch_types_pkg::insn_t [fetch_cfg_pkg::fetch_w-1:0]        words,
   input  fetch_types_pkg::slot_cnt_t                                id_pop_cnt,
   output logic                                                      fq_ready,
   output logic [fetch_cfg_pkg::issue_w-1:0]                         id_valid,
   output fetch_types_pkg::decode_slot_t [fetch_cfg_pkg::issue_w-1:0] id_slot
);
   import fetch_cfg_pkg::*;
   import fetch_types_pkg::*;

   localparam int depth = 1 << queue_p_depth;
   localparam int cnt_w = queue_p_depth + 1;

   fetch_window_t            s2_win;
   insn_t [fetch_w-1:0]      s2_words;
   slot_cnt_t                push_cnt;
   logic [p_fetch_w-1:0]     src_slot [fetch_w];
   logic [queue_p_depth-1:0] wr_slot [fetch_w];
   decode_slot_t             fifo [depth];
   logic [queue_p_depth-1:0] wr_ptr;
   logic [queue_p_depth-1:0] rd_ptr;
   logic [cnt_w-1:0]         count;
   logic [cnt_w-1:0]         count_nxt;

   // Stage 2, the mask is dropped by a flush
   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         s2_win.valid <= '0;
      else if (fq_ready)
         s2_win.valid <= window.valid;
   end

   always_ff @(posedge clk)
   begin
      if (fq_ready)
      begin
         s2_win.pc <= window.pc;
         s2_win.push_off <= window.push_off;
         s2_words <= words;
      end
   end

   // Room for a full window on top of the one held in stage 2
   assign fq_ready = (cnt_w'(depth) - count) >= cnt_w'(2 * fetch_w);

   assign push_cnt = fq_ready ? slot_cnt_t'($countones(s2_win.valid)) : '0;

   // Valid slots are packed from the push offset
   always_comb
   begin
      for (int k = 0; k < fetch_w; k++)
      begin
         src_slot[k] = p_fetch_w'(s2_win.push_off + k);
         wr_slot[k] = wr_ptr + queue_p_depth'(k);
      end
   end

   always_ff @(posedge clk)
   begin
      for (int k = 0; k < fetch_w; k++)
      begin
         if (k < push_cnt)
         begin
            fifo[wr_slot[k]].pc <= s2_win.pc[src_slot[k]];
            fifo[wr_slot[k]].insn <= s2_words[src_slot[k]];
         end
      end
   end

   assign count_nxt = count + cnt_w'(push_cnt) - cnt_w'(id_pop_cnt);

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         wr_ptr <= wr_ptr + queue_p_depth'(push_cnt);
         rd_ptr <= rd_ptr + queue_p_depth'(id_pop_cnt);
         count <= count_nxt;
      end
   end

   // Oldest entries toward decode, id_valid is thermometer coded
   always_comb
   begin
      for (int k = 0; k < issue_w; k++)
      begin
         id_valid[k] = (count > k);
         id_slot[k] = fifo[rd_ptr + queue_p_depth'(k)];
      end
   end

   // Decode takes only what id_valid offers
   assert property (@(posedge clk) disable iff (!rst_n)
      id_pop_cnt <= $countones(id_valid));

   // Ready margin must keep every push inside the buffer
   assert property (@(posedge clk) disable iff (!rst_n || flush)
      (int'(count) + int'(push_cnt) - int'(id_pop_cnt)) <= depth);

endmodule

/* fetch_types_pkg.sv */
package fetch_types_pkg;

   import fetch_cfg_pkg::*;

   typedef logic [pc_w-1:0] pc_t;
   typedef logic [insn_w-1:0] insn_t;

   // Holds 0 to fetch_w
   typedef logic [p_fetch_w:0] slot_cnt_t;

   // One fetch window as seen at the end of stage 1
   typedef struct packed {
      pc_t [fetch_w-1:0]  pc;
      logic [fetch_w-1:0] valid;
      slot_cnt_t          push_off;
   } fetch_window_t;

   // Branch outcome from execute
   typedef struct packed {
      logic valid;
      logic taken;
      pc_t  pc;
      pc_t  target;
   } btb_update_t;

   typedef struct packed {
      logic hit;
      pc_t  tgt;
   } btb_slot_pred_t;

   typedef struct packed {
      btb_slot_pred_t [fetch_w-1:0] slot;
   } btb_pred_t;

   typedef struct packed {
      logic  we;
      pc_t   addr;
      insn_t data;
   } imem_write_t;

   typedef struct packed {
      pc_t   pc;
      insn_t insn;
   } decode_slot_t;

endpackage

/* insn_mem.sv */
`timescale 1ns/100ps

module insn_mem
#(
   parameter int imem_p_words = 8
)
(
   input  logic                                               clk,
   input  fetch_types_pkg::pc_t                               pc_nxt,
   input  fetch_types_pkg::imem_write_t                       wr,
   output fetch_types_pkg::insn_t [fetch_cfg_pkg::fetch_w-1:0] words
);
   import fetch_cfg_pkg::*;
   import fetch_types_pkg::*;

   localparam int n_words = 1 << imem_p_words;

   insn_t                   mem [n_words];
   logic [imem_p_words-1:0] rd_addr [fetch_w];
   logic [imem_p_words-1:0] wr_addr;

   // Window-aligned word addresses, wrapping at the memory size
   always_comb
   begin
      for (int i = 0; i < fetch_w; i++)
      begin
         rd_addr[i] = {pc_nxt[imem_p_words-1:p_fetch_w], p_fetch_w'(i)};
      end
   end

   assign wr_addr = wr.addr[imem_p_words-1:0];

   always_ff @(posedge clk)
   begin
      if (wr.we)
         mem[wr_addr] <= wr.data;
   end

   // Read before write, a write shows up on the next lookup
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < fetch_w; i++)
      begin
         words[i] <= mem[rd_addr[i]];
      end
   end

endmodule

/* tb_fetch_frontend.sv */
`timescale 1ns/100ps

module tb_fetch_frontend;
   import fetch_cfg_pkg::*;
   import fetch_types_pkg::*;

   localparam pc_t reset_pc = 30'h0f0;
   localparam int btb_p_sets = 4;
   localparam int imem_p_words = 8;
   localparam int queue_p_depth = 3;
   localparam int n_phases = 6;
   localparam int max_cycles = n_phases * 400 + 600;

   logic                       clk;
   logic                       rst_n;
   logic                       flush;
   pc_t                        flush_tgt;
   btb_update_t                btb_wb;
   imem_write_t                imem_wr;
   slot_cnt_t                  id_pop_cnt;
   logic [issue_w-1:0]         id_valid;
   decode_slot_t [issue_w-1:0] id_slot;

   // Reference copies of memory and BTB
   insn_t                      m_mem [1 << imem_p_words];
   pc_t                        m_tag [1 << btb_p_sets];
   pc_t                        m_tgt [1 << btb_p_sets];
   logic                       m_vld [1 << btb_p_sets];

   // Expected fetch stream
   pc_t                        gen_pc;
   int                         n_windows;
   int                         rel;
   decode_slot_t               exp_q [$];
   pc_t                        br_list [$];
   int                         errors;
   int                         compared;
   int                         cycles;
   int                         run_kind;
   int                         run_left;

   fetch_frontend
      #(.reset_pc       (reset_pc),
        .btb_p_sets     (btb_p_sets),
        .imem_p_words   (imem_p_words),
        .queue_p_depth  (queue_p_depth))
   DUT
      (.clk             (clk),
       .rst_n           (rst_n),
       .flush           (flush),
       .flush_tgt       (flush_tgt),
       .btb_wb          (btb_wb),
       .imem_wr         (imem_wr),
       .id_pop_cnt      (id_pop_cnt),
       .id_valid        (id_valid),
       .id_slot         (id_slot));

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= max_cycles)
      begin
         $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // rel counts edges since the redirect edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
      rel++;
   endtask

   task automatic write_mem(input pc_t addr, input insn_t data);
      imem_wr.we = 1'b1;
      imem_wr.addr = addr;
      imem_wr.data = data;
      m_mem[addr % (1 << imem_p_words)] = data;
      next_cycle();
      imem_wr.we = 1'b0;
   endtask

   task automatic write_btb(input pc_t bpc, input pc_t target, input logic taken);
      int idx;
      idx = bpc % (1 << btb_p_sets);
      btb_wb.valid = 1'b1;
      btb_wb.taken = taken;
      btb_wb.pc = bpc;
      btb_wb.target = target;
      if (taken)
      begin
         m_vld[idx] = 1'b1;
         m_tag[idx] = bpc >> btb_p_sets;
         m_tgt[idx] = target;
      end
      else if (m_tag[idx] == (bpc >> btb_p_sets))
         m_vld[idx] = 1'b0;
      next_cycle();
      btb_wb.valid = 1'b0;
   endtask

   task automatic start_stream(input pc_t start);
      gen_pc = start;
      exp_q.delete();
      n_windows = 0;
      rel = -1;
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (4) next_cycle();
      rst_n = 1'b1;
      for (int i = 0; i < (1 << btb_p_sets); i++)
         m_vld[i] = 1'b0;
      start_stream(reset_pc);
   endtask

   task automatic do_flush(input pc_t tgt);
      flush = 1'b1;
      flush_tgt = tgt;
      start_stream(tgt);
      next_cycle();
      flush = 1'b0;
   endtask

   // One window from gen_pc cut after the first predicted slot
   task automatic gen_window();
      pc_t          spc;
      pc_t          nxt;
      int           entry;
      int           cnt;
      int           idx;
      logic         taken;
      decode_slot_t ent;
      entry = gen_pc % fetch_w;
      cnt = 0;
      taken = 1'b0;
      nxt = '0;
      for (int i = entry; i < fetch_w; i++)
      begin
         spc = gen_pc - pc_t'(entry) + pc_t'(i);
         if (!taken)
         begin
            ent.pc = spc;
            ent.insn = m_mem[spc % (1 << imem_p_words)];
            exp_q.push_back(ent);
            cnt++;
            idx = spc % (1 << btb_p_sets);
            if (m_vld[idx] && m_tag[idx] == (spc >> btb_p_sets))
            begin
               taken = 1'b1;
               nxt = m_tgt[idx];
            end
         end
      end
      gen_pc = taken ? nxt : gen_pc + pc_t'(cnt);
      n_windows++;
   endtask

   // Mode 0 pops 0 to 2 at random and mode 1 runs of zero or single pops
   task automatic run_stream(input int n_cycles, input int mode);
      int shown;
      int want;
      int n;
      int popped;
      popped = 0;
      for (int c = 0; c < n_cycles; c++)
      begin
         // A window can be visible no sooner than 2 edges after its PC
         while (n_windows < rel - 1)
            gen_window();
         shown = $countones(id_valid);
         if (id_valid == 2'b10)
         begin
            $display("FAILED id_valid got %h, not thermometer coded", id_valid);
            errors++;
         end
         if (shown > exp_q.size())
         begin
            $display("id_valid shows %0d entries while only %0d are undelivered",
                     shown, exp_q.size());
            errors++;
         end
         if (mode == 0)
            want = $urandom % 3;
         else
         begin
            if (run_left == 0)
            begin
               run_kind = $urandom % 2;
               run_left = 8 + $urandom % 24;
            end
            run_left--;
            want = run_kind;
         end
         n = (want < shown) ? want : shown;
         if (n > exp_q.size())
            n = exp_q.size();
         for (int k = 0; k < n; k++)
         begin
            if (id_slot[k].pc !== exp_q[k].pc)
            begin
               $display("FAILED id_slot[%0d].pc got %h expected %h",
                        k, id_slot[k].pc, exp_q[k].pc);
               errors++;
            end
            if (id_slot[k].insn !== exp_q[k].insn)
            begin
               $display("FAILED id_slot[%0d].insn got %h expected %h",
                        k, id_slot[k].insn, exp_q[k].insn);
               errors++;
            end
            compared++;
         end
         for (int k = 0; k < n; k++)
            void'(exp_q.pop_front());
         popped += n;
         id_pop_cnt = slot_cnt_t'(n);
         next_cycle();
      end
      id_pop_cnt = '0;
      if (popped == 0)
      begin
         $display("No instruction was delivered during a run of %0d cycles", n_cycles);
         errors++;
      end
   endtask

   // Writes land before the redirect so the new stream is fixed
   task automatic run_phase(input logic use_reset, input int n_mem, input int n_taken,
                            input logic odd_tgt, input int n_clear, input pc_t base,
                            input int n_cycles, input int mode);
      pc_t bpc;
      pc_t tgt;
      int  pick;
      for (int i = 0; i < n_mem; i++)
         write_mem(pc_t'($urandom % (1 << imem_p_words)), $urandom);
      for (int i = 0; i < n_taken; i++)
      begin
         bpc = base + pc_t'($urandom % 40);
         tgt = base + pc_t'($urandom % 64);
         if (odd_tgt)
            tgt = tgt | 30'h1;
         if (tgt == bpc)
            tgt = tgt + 30'h2;
         write_btb(bpc, tgt, 1'b1);
         br_list.push_back(bpc);
      end
      for (int i = 0; i < n_clear && br_list.size() > 0; i++)
      begin
         pick = $urandom % br_list.size();
         write_btb(br_list[pick], '0, 1'b0);
      end
      next_cycle();
      if (use_reset)
         apply_reset();
      else
         do_flush(base);
      run_stream(n_cycles, mode);
   endtask

   initial
   begin
      rst_n = 1'b0;
      flush = 1'b0;
      flush_tgt = '0;
      btb_wb = '0;
      imem_wr = '0;
      id_pop_cnt = '0;
      errors = 0;
      compared = 0;
      cycles = 0;
      run_kind = 0;
      run_left = 0;
      for (int i = 0; i < (1 << btb_p_sets); i++)
      begin
         m_vld[i] = 1'b0;
         m_tag[i] = '0;
         m_tgt[i] = '0;
      end
      void'($urandom(32'h3cd7));
      apply_reset();
      // Whole memory with each word a function of its full address
      for (int a = 0; a < (1 << imem_p_words); a++)
         write_mem(pc_t'(a), (a * 32'h9e37_79b9) ^ 32'h1357_2468);
      run_phase(1'b1, 0, 0, 1'b0, 0, reset_pc, 200, 0);
      run_phase(1'b0, 16, 6, 1'b0, 0, 30'h040, 250, 0);
      run_phase(1'b0, 8, 4, 1'b1, 0, 30'h081, 250, 0);
      run_phase(1'b0, 8, 0, 1'b0, 6, 30'h040, 250, 0);
      run_phase(1'b0, 8, 3, 1'b0, 0, 30'h3f7, 350, 1);
      run_phase(1'b1, 16, 4, 1'b0, 0, reset_pc, 250, 0);
      $display("Run complete: %0d errors, %0d slots compared", errors, compared);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* vlog.f */
fetch_cfg_pkg.sv
fetch_types_pkg.sv
fetch_pc_gen.sv
branch_target_buf.sv
insn_mem.sv
fetch_queue.sv
fetch_frontend.sv
tb_fetch_frontend.sv
